//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cps2_main_bus
RTL_TOP   ?= cps2_main_bus
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cps2_addr_decode.sv
`timescale 1ns/1ps
`include "cps2_macros.svh"

module cps2_addr_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cen,
    input  cps2_pkg::cps2_bus_s bus,
    input  logic [3:0]          oram_nib,
    output cps2_pkg::cps2_sel_s sel,
    output logic                ram_cs,
    output logic                vram_cs,
    output logic                oram_cs,
    output logic [17:1]         addr,
    output logic [21:1]         rom_addr,
    output logic [23:1]         main2qs_addr,
    output logic                one_wait
);
    logic [23:1] a;
    logic        wr_ds;
    logic        wr_ds_q;
    logic        wr_dly;
    logic        reg_ram;
    logic        reg_vram;
    logic        reg_oram;

    assign a     = bus.addr;
    assign wr_ds = !bus.rnw && !(bus.uds_n && bus.lds_n);

    // Region selects, sampled while the address strobe is low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (!bus.as_n) begin
            sel.rom    <= a[23:22] == `CPS2_ROM_HI;
            sel.ram    <= a[23:16] == `CPS2_RAM_PAGE;
            // Top 64K page of the VRAM window is not VRAM
            sel.vram   <= a[23:18] == `CPS2_VRAM_BASE && a[17:16] != 2'b11;
            sel.oram   <= a[23:20] == `CPS2_ORAM_NIB && a[19:16] == oram_nib;
            sel.io     <= a[23:19] == `CPS2_IO_BASE;
            sel.objcfg <= a[23:20] == `CPS2_OBJCFG_NIB && !bus.rnw;
            sel.qs     <= a[23:20] == `CPS2_QS_NIB && a[19:17] == 3'd0;
        end else begin
            sel <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!bus.as_n) begin
            rom_addr     <= a[21:1];
            main2qs_addr <= a;
        end
    end

    // Strobe seen one clock back, so the cen that closes a write still catches it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ds_q  <= 1'b0;
            wr_dly   <= 1'b0;
            reg_ram  <= 1'b0;
            reg_vram <= 1'b0;
            reg_oram <= 1'b0;
        end else begin
            wr_ds_q <= wr_ds;
            if (cpu_cen) begin
                wr_dly   <= wr_ds_q;
                reg_ram  <= sel.ram;
                reg_vram <= sel.vram;
                reg_oram <= sel.oram;
            end
        end
    end

    // Hold memory selects past the end of a write so the
    // SDRAM side never sees a stray read request
    assign ram_cs  = sel.ram  | (wr_dly & reg_ram);
    assign vram_cs = sel.vram | (wr_dly & reg_vram);
    assign oram_cs = sel.oram | (wr_dly & reg_oram);

    // RAM and VRAM share the SDRAM, keep RAM in its own 32K words
    assign addr = ram_cs ? {2'b00, a[15:1]} : a[17:1];

    assign one_wait = !bus.as_n &&
                      (a[23:20] < `CPS2_WAIT_LO_NIB || a[23:20] >= `CPS2_WAIT_HI_NIB);

endmodule

//--- cps2_dtack.sv
`timescale 1ns/1ps

module cps2_dtack (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cen,
    input  logic                as_n,
    input  cps2_pkg::cps2_sel_s sel,
    input  logic                one_wait,
    input  logic                rom_ok,
    input  logic                ram_ok,
    input  logic                main2qs_waitn,
    output logic                dtack_n
);
    logic bus_cs;
    logic bus_busy;
    logic waited;

    assign bus_cs = |sel;

    // Memory and sound side hold the acknowledge off
    assign bus_busy = (sel.rom & ~rom_ok) |
                      ((sel.ram | sel.vram | sel.oram) & ~ram_ok) |
                      (sel.qs & ~main2qs_waitn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n <= 1'b1;
            waited  <= 1'b0;
        end else if (as_n) begin
            dtack_n <= 1'b1;
            waited  <= 1'b0;
        end else if (cpu_cen && bus_cs) begin
            // First cen with a select only counts the extra wait
            waited <= 1'b1;
            if (!bus_busy && (waited || !one_wait)) begin
                dtack_n <= 1'b0;
            end
        end
    end

endmodule

//--- cps2_io_regs.sv
`timescale 1ns/1ps
`include "cps2_macros.svh"

module cps2_io_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_cen,
    input  cps2_pkg::cps2_bus_s    bus,
    input  logic                   io_cs,
    input  logic                   objcfg_cs,
    output cps2_pkg::cps2_io_sel_s io_sel,
    output cps2_pkg::cps2_eeprom_s eeprom,
    output logic                   z80_rstn,
    output logic                   obank,
    output logic [15:0]            oram_base
);
    logic [5:0] ofs;
    logic       wr_lo;
    logic       wr_hi;

    assign ofs   = bus.addr[8:3];
    assign wr_lo = !bus.rnw && !bus.lds_n;
    assign wr_hi = !bus.rnw && !bus.uds_n;

    always_comb begin
        io_sel.ppu1   = io_cs && bus.addr[8:6] == `CPS2_PPU1_OFS;
        io_sel.ppu2   = io_cs && bus.addr[8:6] == `CPS2_PPU2_OFS;
        io_sel.in0    = io_cs && ofs == `CPS2_IN0_OFS;
        io_sel.in1    = io_cs && ofs == `CPS2_IN1_OFS;
        io_sel.in2    = io_cs && ofs == `CPS2_IN2_OFS;
        io_sel.vol    = io_cs && ofs == `CPS2_VOL_OFS;
        // Same offset, the byte lane picks the register
        io_sel.out    = io_cs && ofs == `CPS2_OUT_OFS && wr_lo;
        io_sel.eeprom = io_cs && ofs == `CPS2_OUT_OFS && wr_hi;
        io_sel.obank  = io_cs && ofs == `CPS2_OBANK_OFS && wr_lo;
        io_sel.sys    = io_sel.in0 | io_sel.in1 | io_sel.in2 | io_sel.eeprom;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom    <= '0;
            z80_rstn  <= 1'b0;
            obank     <= 1'b0;
            oram_base <= 16'h0000;
        end else if (cpu_cen) begin
            if (io_sel.eeprom) begin
                eeprom.scs  <= bus.dout[14];
                eeprom.sclk <= bus.dout[13];
                eeprom.sdi  <= bus.dout[12];
            end
            if (io_sel.out) begin
                z80_rstn <= bus.dout[3];
            end
            if (io_sel.obank) begin
                obank <= bus.dout[0];
            end
            // Object RAM base, written bytewise
            if (objcfg_cs && bus.addr[3:1] == `CPS2_OBJCFG_BASE_OFS) begin
                if (!bus.uds_n) begin
                    oram_base[15:8] <= bus.dout[15:8];
                end
                if (!bus.lds_n) begin
                    oram_base[7:0] <= bus.dout[7:0];
                end
            end
        end
    end

endmodule

//--- cps2_macros.svh
`ifndef CPS2_MACROS_SVH
`define CPS2_MACROS_SVH

// Region match values on the upper word address bits
`define CPS2_ROM_HI       (2'b00)
`define CPS2_RAM_PAGE     (8'hff)
`define CPS2_VRAM_BASE    (6'b100100)
`define CPS2_ORAM_NIB     (4'h7)
`define CPS2_IO_BASE      (5'b10000)
`define CPS2_OBJCFG_NIB   (4'h4)
`define CPS2_QS_NIB       (4'h6)

// Extra wait applies below 0x500000 and from 0x800000 up
`define CPS2_WAIT_LO_NIB  (4'h5)
`define CPS2_WAIT_HI_NIB  (4'h8)

// I/O offsets on address bits 8..3
`define CPS2_IN0_OFS      (6'h00)
`define CPS2_IN1_OFS      (6'h02)
`define CPS2_IN2_OFS      (6'h04)
`define CPS2_VOL_OFS      (6'h06)
`define CPS2_OUT_OFS      (6'h08)
`define CPS2_OBANK_OFS    (6'h1c)
// PPU windows match on address bits 8..6
`define CPS2_PPU1_OFS     (3'b100)
`define CPS2_PPU2_OFS     (3'b101)

// Object config register holding the object RAM base
`define CPS2_OBJCFG_BASE_OFS (3'd0)

`define CPS2_JOY_BUT6     (2'b00)

`endif

//--- cps2_main_bus.sv
`timescale 1ns/1ps

module cps2_main_bus (
    input  logic                   clk,
    input  logic                   rst,
    input  cps2_pkg::cps2_bus_s    bus,
    input  logic                   cpu_cen,
    input  cps2_pkg::cps2_cab_s    cab,
    input  logic [1:0]             joymode,
    input  logic [15:0]            ram_data,
    input  logic                   ram_ok,
    input  logic [15:0]            rom_data,
    input  logic                   rom_ok,
    input  logic [15:0]            mmr_dout,
    input  logic [7:0]             main2qs_din,
    input  logic                   main2qs_waitn,
    input  logic [12:0]            volume,
    output logic [15:0]            cpu_din,
    output logic                   dtack_n,
    output logic [17:1]            addr,
    output logic [21:1]            rom_addr,
    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic                   vram_cs,
    output logic                   oram_cs,
    output logic                   ppu1_cs,
    output logic                   ppu2_cs,
    output logic                   objcfg_cs,
    output logic                   main2qs_cs,
    output logic [23:1]            main2qs_addr,
    output cps2_pkg::cps2_eeprom_s eeprom,
    output logic                   z80_rstn,
    output logic                   obank,
    output logic [15:0]            oram_base
);
    import cps2_pkg::*;

    cps2_sel_s    sel;
    cps2_io_sel_s io_sel;
    logic         one_wait;

    assign rom_cs     = sel.rom;
    assign objcfg_cs  = sel.objcfg;
    assign main2qs_cs = sel.qs;
    assign ppu1_cs    = io_sel.ppu1;
    assign ppu2_cs    = io_sel.ppu2;

    cps2_addr_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .cpu_cen      (cpu_cen),
        .bus          (bus),
        .oram_nib     (oram_base[11:8]),
        .sel          (sel),
        .ram_cs       (ram_cs),
        .vram_cs      (vram_cs),
        .oram_cs      (oram_cs),
        .addr         (addr),
        .rom_addr     (rom_addr),
        .main2qs_addr (main2qs_addr),
        .one_wait     (one_wait)
    );

    cps2_io_regs u_io (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus       (bus),
        .io_cs     (sel.io),
        .objcfg_cs (sel.objcfg),
        .io_sel    (io_sel),
        .eeprom    (eeprom),
        .z80_rstn  (z80_rstn),
        .obank     (obank),
        .oram_base (oram_base)
    );

    cps2_read_path u_read (
        .clk         (clk),
        .rst         (rst),
        .cab         (cab),
        .joymode     (joymode),
        .io_sel      (io_sel),
        .sel         (sel),
        .ram_data    (ram_data),
        .rom_data    (rom_data),
        .mmr_dout    (mmr_dout),
        .main2qs_din (main2qs_din),
        .volume      (volume),
        .cpu_din     (cpu_din)
    );

    cps2_dtack u_dtack (
        .clk           (clk),
        .rst           (rst),
        .cpu_cen       (cpu_cen),
        .as_n          (bus.as_n),
        .sel           (sel),
        .one_wait      (one_wait),
        .rom_ok        (rom_ok),
        .ram_ok        (ram_ok),
        .main2qs_waitn (main2qs_waitn),
        .dtack_n       (dtack_n)
    );

endmodule

//--- cps2_pkg.sv
package cps2_pkg;

    // CPU bus as driven by the 68000 side
    typedef struct packed {
        logic [23:1] addr;
        logic        as_n;
        logic        rnw;
        logic        uds_n;
        logic        lds_n;
        logic [15:0] dout;
    } cps2_bus_s;

    // Registered region selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic oram;
        logic io;
        logic objcfg;
        logic qs;
    } cps2_sel_s;

    // Selects inside the I/O window
    typedef struct packed {
        logic ppu1;
        logic ppu2;
        logic in0;
        logic in1;
        logic in2;
        logic vol;
        logic out;
        logic eeprom;
        logic obank;
        logic sys;
    } cps2_io_sel_s;

    // Cabinet inputs, joysticks active low
    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [9:0] joy3;
        logic [9:0] joy4;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       dip_test;
        logic       eeprom_sdo;
    } cps2_cab_s;

    typedef struct packed {
        logic scs;
        logic sclk;
        logic sdi;
    } cps2_eeprom_s;

    typedef struct packed {
        logic [7:0] p4;
        logic [7:0] p3;
    } cps2_in1_players_s;

    // Six-button layout of the second input word
    typedef struct packed {
        logic [9:0] pad_hi;
        logic [1:0] j2_btn;
        logic       pad_mid;
        logic [2:0] j1_btn;
    } cps2_in1_buttons_s;

    typedef union packed {
        cps2_in1_players_s players;
        cps2_in1_buttons_s buttons;
    } cps2_in1_u;

endpackage

//--- cps2_read_path.sv
`timescale 1ns/1ps
`include "cps2_macros.svh"

module cps2_read_path (
    input  logic                   clk,
    input  logic                   rst,
    input  cps2_pkg::cps2_cab_s    cab,
    input  logic [1:0]             joymode,
    input  cps2_pkg::cps2_io_sel_s io_sel,
    input  cps2_pkg::cps2_sel_s    sel,
    input  logic [15:0]            ram_data,
    input  logic [15:0]            rom_data,
    input  logic [15:0]            mmr_dout,
    input  logic [7:0]             main2qs_din,
    input  logic [12:0]            volume,
    output logic [15:0]            cpu_din
);
    import cps2_pkg::*;

    logic        but6;
    logic [15:0] in0;
    cps2_in1_u   in1;
    logic [15:0] in2;
    logic [15:0] sys_data;

    assign but6 = joymode == `CPS2_JOY_BUT6;

    // Input words, refreshed every clock
    always_ff @(posedge clk) begin
        in0 <= {cab.joy2[7:0], cab.joy1[7:0]};
        in2 <= {cab.coin, cab.start, 5'h1f, cab.service, cab.dip_test, cab.eeprom_sdo};
        if (but6) begin
            in0[15] <= 1'b1;
            in0[7]  <= 1'b1;
            // Buttons 4 to 6 move into the second word
            in1.buttons.pad_hi  <= '1;
            in1.buttons.j2_btn  <= cab.joy2[8:7];
            in1.buttons.pad_mid <= 1'b1;
            in1.buttons.j1_btn  <= cab.joy1[9:7];
            in2[14] <= cab.joy2[9];
        end else begin
            in1.players.p4 <= cab.joy4[7:0];
            in1.players.p3 <= cab.joy3[7:0];
        end
    end

    always_comb begin
        if (io_sel.in0) begin
            sys_data = in0;
        end else if (io_sel.in1) begin
            sys_data = in1;
        end else if (io_sel.in2) begin
            sys_data = in2;
        end else begin
            sys_data = 16'hffff;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'hffff;
        end else if (io_sel.sys) begin
            cpu_din <= sys_data;
        end else if (sel.ram | sel.vram | sel.oram) begin
            cpu_din <= ram_data;
        end else if (sel.rom) begin
            cpu_din <= rom_data;
        end else if (io_sel.ppu2) begin
            cpu_din <= mmr_dout;
        end else if (io_sel.vol) begin
            cpu_din <= {3'b111, volume};
        end else if (sel.qs) begin
            cpu_din <= {8'hff, main2qs_din};
        end else begin
            cpu_din <= 16'hffff;
        end
    end

endmodule

//--- tb_cps2_main_bus.sv
`timescale 1ns/1ps

module tb_cps2_main_bus;
    import cps2_pkg::*;

    // About 600 cycles of tests plus a wide margin
    localparam int CYCLE_LIMIT = 4000;
    localparam int ACK_LIMIT   = 40;
    localparam logic [1:0] JOY_NORMAL = 2'b01;
    localparam logic [1:0] JOY_BUT6   = 2'b00;

    logic         clk;
    logic         rst;
    logic         cpu_cen;
    cps2_bus_s    bus;
    cps2_cab_s    cab;
    logic [1:0]   joymode;
    logic [15:0]  ram_data;
    logic         ram_ok;
    logic [15:0]  rom_data;
    logic         rom_ok;
    logic [15:0]  mmr_dout;
    logic [7:0]   main2qs_din;
    logic         main2qs_waitn;
    logic [12:0]  volume;
    logic [15:0]  cpu_din;
    logic         dtack_n;
    logic [17:1]  addr;
    logic [21:1]  rom_addr;
    logic         rom_cs;
    logic         ram_cs;
    logic         vram_cs;
    logic         oram_cs;
    logic         ppu1_cs;
    logic         ppu2_cs;
    logic         objcfg_cs;
    logic         main2qs_cs;
    logic [23:1]  main2qs_addr;
    cps2_eeprom_s eeprom;
    logic         z80_rstn;
    logic         obank;
    logic [15:0]  oram_base;
    int           errors;
    int           checks;
    int           cycles;

    // Memory contents follow from the word address
    function automatic logic [15:0] ram_word(input logic [23:1] a);
        return a[16:1] ^ {a[23:17], 9'h0a5};
    endfunction

    function automatic logic [15:0] rom_word(input logic [23:1] a);
        return {a[8:1], a[16:9]} ^ {a[23:17], 9'h13c};
    endfunction

    assign ram_data = ram_word(bus.addr);
    assign rom_data = rom_word(bus.addr);

    cps2_main_bus u_dut (
        .clk           (clk),
        .rst           (rst),
        .bus           (bus),
        .cpu_cen       (cpu_cen),
        .cab           (cab),
        .joymode       (joymode),
        .ram_data      (ram_data),
        .ram_ok        (ram_ok),
        .rom_data      (rom_data),
        .rom_ok        (rom_ok),
        .mmr_dout      (mmr_dout),
        .main2qs_din   (main2qs_din),
        .main2qs_waitn (main2qs_waitn),
        .volume        (volume),
        .cpu_din       (cpu_din),
        .dtack_n       (dtack_n),
        .addr          (addr),
        .rom_addr      (rom_addr),
        .rom_cs        (rom_cs),
        .ram_cs        (ram_cs),
        .vram_cs       (vram_cs),
        .oram_cs       (oram_cs),
        .ppu1_cs       (ppu1_cs),
        .ppu2_cs       (ppu2_cs),
        .objcfg_cs     (objcfg_cs),
        .main2qs_cs    (main2qs_cs),
        .main2qs_addr  (main2qs_addr),
        .eeprom        (eeprom),
        .z80_rstn      (z80_rstn),
        .obank         (obank),
        .oram_base     (oram_base)
    );

    always #10 clk = ~clk;

    // CPU clock enable on every other clock
    always @(posedge clk) begin
        #2;
        cpu_cen = ~cpu_cen;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d clock cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic start_cycle(input logic [23:0] a, input logic rnw, input logic [1:0] ds_n,
                               input logic [15:0] wdata);
        bus.addr  = a[23:1];
        bus.rnw   = rnw;
        bus.uds_n = ds_n[1];
        bus.lds_n = ds_n[0];
        bus.dout  = wdata;
        bus.as_n  = 1'b0;
    endtask

    task automatic wait_ack(output int edges);
        edges = 0;
        while (dtack_n && edges < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            edges++;
        end
        if (dtack_n) begin
            errors++;
            $display("No DTACK within %0d cycles at address %h", ACK_LIMIT, {bus.addr, 1'b0});
        end
    endtask

    task automatic end_cycle;
        bus.as_n  = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        bus.rnw   = 1'b1;
        @(posedge clk);
        #2;
        check("dtack_n release", 32'(dtack_n), 32'd1);
    endtask

    task automatic bus_cycle(input logic [23:0] a, input logic rnw, input logic [1:0] ds_n,
                             input logic [15:0] wdata, output logic [15:0] rdata,
                             output int edges);
        start_cycle(a, rnw, ds_n, wdata);
        wait_ack(edges);
        rdata = cpu_din;
        end_cycle();
    endtask

    // exp_sel is {rom, ram, vram, oram, objcfg, qs}
    task automatic decode_case(input logic [23:0] a, input logic rnw, input logic [5:0] exp_sel,
                               input logic exp_ack);
        logic [16:0] exp_addr;
        logic        exp_ppu1;
        logic        exp_ppu2;
        int          edges;
        start_cycle(a, rnw, 2'b00, 16'h1234);
        @(posedge clk);
        #2;
        exp_addr = exp_sel[4] ? {2'b00, a[15:1]} : a[17:1];
        exp_ppu1 = exp_ack && exp_sel == 6'd0 && a[8:6] == 3'b100;
        exp_ppu2 = exp_ack && exp_sel == 6'd0 && a[8:6] == 3'b101;
        check("selects", 32'({rom_cs, ram_cs, vram_cs, oram_cs, objcfg_cs, main2qs_cs}),
              32'(exp_sel));
        check("ppu1_cs", 32'(ppu1_cs), 32'(exp_ppu1));
        check("ppu2_cs", 32'(ppu2_cs), 32'(exp_ppu2));
        check("addr", 32'(addr), 32'(exp_addr));
        check("rom_addr", 32'(rom_addr), 32'(a[21:1]));
        check("main2qs_addr", 32'(main2qs_addr), 32'(a[23:1]));
        if (exp_ack) begin
            wait_ack(edges);
        end else begin
            idle(6);
            check("dtack_n without select", 32'(dtack_n), 32'd1);
        end
        end_cycle();
        idle(3);
    endtask

    task automatic reset_state;
        check("selects in reset", 32'({rom_cs, ram_cs, vram_cs, oram_cs, objcfg_cs,
                                       main2qs_cs, ppu1_cs, ppu2_cs}), 32'd0);
        check("dtack_n", 32'(dtack_n), 32'd1);
        check("cpu_din", 32'(cpu_din), 32'h0000_ffff);
        check("z80_rstn", 32'(z80_rstn), 32'd0);
        check("eeprom", 32'(eeprom), 32'd0);
        check("obank", 32'(obank), 32'd0);
        check("oram_base", 32'(oram_base), 32'd0);
    endtask

    task automatic region_decode;
        decode_case(24'h000000, 1'b1, 6'b100000, 1'b1);
        decode_case(24'h3ffffe, 1'b1, 6'b100000, 1'b1);
        decode_case(24'h400000, 1'b1, 6'b000000, 1'b0);
        decode_case(24'hff0000, 1'b1, 6'b010000, 1'b1);
        decode_case(24'hfffffe, 1'b1, 6'b010000, 1'b1);
        decode_case(24'hfefffe, 1'b1, 6'b000000, 1'b0);
        decode_case(24'h900000, 1'b1, 6'b001000, 1'b1);
        decode_case(24'h92fffe, 1'b1, 6'b001000, 1'b1);
        decode_case(24'h930000, 1'b1, 6'b000000, 1'b0);
        // Object RAM base is still zero here
        decode_case(24'h700010, 1'b1, 6'b000100, 1'b1);
        decode_case(24'h710000, 1'b1, 6'b000000, 1'b0);
        decode_case(24'h800100, 1'b1, 6'b000000, 1'b1);
        decode_case(24'h800140, 1'b1, 6'b000000, 1'b1);
        decode_case(24'h87fffe, 1'b1, 6'b000000, 1'b1);
        decode_case(24'h880000, 1'b1, 6'b000000, 1'b0);
        decode_case(24'h400002, 1'b0, 6'b000010, 1'b1);
        decode_case(24'h600000, 1'b1, 6'b000001, 1'b1);
        decode_case(24'h61fffe, 1'b1, 6'b000001, 1'b1);
        decode_case(24'h620000, 1'b1, 6'b000000, 1'b0);
    endtask

    task automatic io_writes;
        logic [15:0] d;
        logic [2:0]  pins;
        int          edges;
        pins = 3'($urandom % 7 + 1);
        // Upper byte lane only while the lower byte carries bit 3
        bus_cycle(24'h800040, 1'b0, 2'b01, {1'b0, pins, 12'h008}, d, edges);
        check("eeprom", 32'(eeprom), 32'(pins));
        check("z80_rstn", 32'(z80_rstn), 32'd0);
        bus_cycle(24'h800040, 1'b0, 2'b10, 16'h0008, d, edges);
        check("z80_rstn", 32'(z80_rstn), 32'd1);
        check("eeprom", 32'(eeprom), 32'(pins));
        bus_cycle(24'h8000e0, 1'b0, 2'b10, 16'h0001, d, edges);
        check("obank", 32'(obank), 32'd1);
        bus_cycle(24'h400000, 1'b0, 2'b01, 16'h0a00, d, edges);
        bus_cycle(24'h400000, 1'b0, 2'b10, 16'h005c, d, edges);
        check("oram_base", 32'(oram_base), 32'h0000_0a5c);
        decode_case(24'h7a0100, 1'b1, 6'b000100, 1'b1);
        decode_case(24'h7b0100, 1'b1, 6'b000000, 1'b0);
        decode_case(24'h700100, 1'b1, 6'b000000, 1'b0);
    endtask

    // Expected layout of in0 to in2 by index
    function automatic logic [15:0] expect_input(input int idx, input logic six,
                                                 input cps2_cab_s c);
        logic [15:0] w;
        case (idx)
            0: begin
                w = {c.joy2[7:0], c.joy1[7:0]};
                if (six) begin
                    w[15] = 1'b1;
                    w[7]  = 1'b1;
                end
            end
            1: begin
                w = six ? {10'h3ff, c.joy2[8:7], 1'b1, c.joy1[9:7]}
                        : {c.joy4[7:0], c.joy3[7:0]};
            end
            default: begin
                w = {c.coin, c.start, 5'h1f, c.service, c.dip_test, c.eeprom_sdo};
                if (six) begin
                    w[14] = c.joy2[9];
                end
            end
        endcase
        return w;
    endfunction

    task automatic input_reads;
        logic [63:0] r;
        logic [15:0] d;
        int          edges;
        for (int m = 0; m < 4; m++) begin
            r = {$urandom, $urandom};
            cab = r[$bits(cps2_cab_s)-1:0];
            joymode = (m % 2 == 1) ? JOY_BUT6 : JOY_NORMAL;
            // Let the registered input words settle
            idle(3);
            for (int i = 0; i < 3; i++) begin
                bus_cycle(24'h800000 + 24'(i * 16), 1'b1, 2'b00, 16'h0000, d, edges);
                check("cpu_din input word", 32'(d), 32'(expect_input(i, m % 2 == 1, cab)));
            end
            bus_cycle(24'h800050, 1'b1, 2'b00, 16'h0000, d, edges);
            check("cpu_din unmapped I/O", 32'(d), 32'h0000_ffff);
        end
    endtask

    // Busy source by which is 0 for RAM, 1 for ROM and 2 for QSound
    task automatic ready_read(input logic [23:0] a, input int which);
        logic [15:0] d;
        logic [15:0] exp;
        int          edges;
        int          hold;
        hold = 3 + int'($urandom % 8);
        case (which)
            0: begin
                ram_ok = 1'b0;
                exp = ram_word(a[23:1]);
            end
            1: begin
                rom_ok = 1'b0;
                exp = rom_word(a[23:1]);
            end
            default: begin
                main2qs_waitn = 1'b0;
                exp = {8'hff, main2qs_din};
            end
        endcase
        fork
            bus_cycle(a, 1'b1, 2'b00, 16'h0000, d, edges);
            begin
                repeat (hold) @(posedge clk);
                #2;
                ram_ok = 1'b1;
                rom_ok = 1'b1;
                main2qs_waitn = 1'b1;
            end
        join
        check("cpu_din", 32'(d), 32'(exp));
        check("dtack_n held while busy", 32'(edges > hold), 32'd1);
    endtask

    task automatic waits_and_sources;
        logic [15:0] d;
        int          edges;
        mmr_dout    = 16'($urandom);
        main2qs_din = 8'($urandom);
        volume      = 13'($urandom);
        ready_read(24'hff1234, 0);
        ready_read(24'h910a06, 0);
        ready_read(24'h012344, 1);
        ready_read(24'h61f00a, 2);
        bus_cycle(24'h800030, 1'b1, 2'b00, 16'h0000, d, edges);
        check("cpu_din volume", 32'(d), 32'({3'b111, volume}));
        bus_cycle(24'h800140, 1'b1, 2'b00, 16'h0000, d, edges);
        check("cpu_din mmr_dout", 32'(d), 32'(mmr_dout));
    endtask

    task automatic strobe_guard;
        logic [15:0] d;
        int          edges;
        idle(4);
        bus_cycle(24'hff0200, 1'b0, 2'b00, 16'hbeef, d, edges);
        check("ram_cs after write", 32'(ram_cs), 32'd1);
        // Two cen periods
        idle(4);
        check("ram_cs after two cen", 32'(ram_cs), 32'd0);
        bus_cycle(24'hff0200, 1'b1, 2'b00, 16'h0000, d, edges);
        check("ram_cs after read", 32'(ram_cs), 32'd0);
        check("cpu_din RAM", 32'(d), 32'(ram_word(23'h7f8100)));
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        cpu_cen       = 1'b0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        bus           = '0;
        bus.as_n      = 1'b1;
        bus.rnw       = 1'b1;
        bus.uds_n     = 1'b1;
        bus.lds_n     = 1'b1;
        cab           = '1;
        joymode       = JOY_NORMAL;
        ram_ok        = 1'b1;
        rom_ok        = 1'b1;
        mmr_dout      = 16'h0000;
        main2qs_din   = 8'h00;
        main2qs_waitn = 1'b1;
        volume        = 13'h0000;
        void'($urandom(32'h97503db9));
        repeat (8) @(posedge clk);
        #2;
        reset_state();
        rst = 1'b0;
        idle(2);
        region_decode();
        io_writes();
        input_reads();
        waits_and_sources();
        strobe_guard();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
cps2_pkg.sv
cps2_addr_decode.sv
cps2_io_regs.sv
cps2_read_path.sv
cps2_dtack.sv
cps2_main_bus.sv
tb_cps2_main_bus.sv
